// File: Makefile
# Verilator build and run for the PC Engine pad port testbench

SIM       := verilator
TOP       := tb_pce_pad_port
FILELIST  := pce_pad_port.f
SIM_FLAGS := --binary --timing --timescale 1ns/1ps -Wno-fatal
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_TEXT := Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/pad_trace.txt
# clr sel multitap six mouse pad0 pad1 pad2 pad3 pad4 strobe dx dy btn expected_nibble
# All hex; pad bits 11:8 are random while six is 0; a line "test <name>" starts a test
test reset_clear
1 0 0 0 0 05A 03C 096 0E1 027 0 00 00 0 0
1 1 0 0 0 05A 03C 096 0E1 027 0 00 00 0 0
test single_pad
0 0 0 0 0 05A 03C 096 0E1 027 0 00 00 0 A
0 1 0 0 0 05A 03C 096 0E1 027 0 00 00 0 3
0 1 0 0 0 001 03C 096 0E1 027 0 00 00 0 D
0 1 0 0 0 002 03C 096 0E1 027 0 00 00 0 B
0 1 0 0 0 004 03C 096 0E1 027 0 00 00 0 E
0 1 0 0 0 008 03C 096 0E1 027 0 00 00 0 7
0 0 0 0 0 010 03C 096 0E1 027 0 00 00 0 E
0 0 0 0 0 080 03C 096 0E1 027 0 00 00 0 7
test multitap
1 0 1 0 0 05A 03C 096 0E1 027 0 00 00 0 0
0 0 1 0 0 05A 03C 096 0E1 027 0 00 00 0 A
0 1 1 0 0 05A 03C 096 0E1 027 0 00 00 0 6
0 0 1 0 0 05A 03C 096 0E1 027 0 00 00 0 C
0 1 1 0 0 05A 03C 096 0E1 027 0 00 00 0 A
0 0 1 0 0 05A 03C 096 0E1 027 0 00 00 0 6
0 1 1 0 0 05A 03C 096 0E1 027 0 00 00 0 D
0 0 1 0 0 05A 03C 096 0E1 027 0 00 00 0 1
0 1 1 0 0 05A 03C 096 0E1 027 0 00 00 0 8
0 0 1 0 0 05A 03C 096 0E1 027 0 00 00 0 D
0 1 1 0 0 05A 03C 096 0E1 027 0 00 00 0 F
0 0 1 0 0 05A 03C 096 0E1 027 0 00 00 0 F
1 0 1 0 0 05A 03C 096 0E1 027 0 00 00 0 0
test six_button
0 0 0 1 0 35A 803 C96 4E1 F27 0 00 00 0 A
1 0 0 1 0 35A 803 C96 4E1 F27 0 00 00 0 0
0 0 0 1 0 35A 803 C96 4E1 F27 0 00 00 0 C
0 1 0 1 0 35A 803 C96 4E1 F27 0 00 00 0 0
1 1 0 1 0 35A 803 C96 4E1 F27 0 00 00 0 0
0 1 0 1 0 35A 803 C96 4E1 F27 0 00 00 0 3
1 0 0 1 0 A5A 803 C96 4E1 F27 0 00 00 0 0
0 0 0 1 0 A5A 803 C96 4E1 F27 0 00 00 0 5
1 0 0 0 0 05A 03C 096 0E1 027 0 00 00 0 0
0 0 0 0 0 05A 03C 096 0E1 027 0 00 00 0 A
test mouse
1 0 0 0 1 05A 03C 096 0E1 027 0 00 00 0 0
0 0 0 0 1 05A 03C 096 0E1 027 1 05 23 0 B
1 1 0 0 1 05A 03C 096 0E1 027 1 05 23 0 0
0 0 0 0 1 05A 03C 096 0E1 027 1 05 23 1 9
1 0 0 0 1 05A 03C 096 0E1 027 1 05 23 1 0
0 0 0 0 1 05A 03C 096 0E1 027 1 05 23 2 A
1 0 0 0 1 05A 03C 096 0E1 027 1 05 23 2 0
0 0 0 0 1 0DA 03C 096 0E1 027 1 05 23 1 1
1 0 0 0 1 05A 03C 096 0E1 027 1 05 23 0 0
0 1 0 0 1 05A 03C 096 0E1 027 1 05 23 0 F
1 1 0 0 1 05A 03C 096 0E1 027 1 05 23 0 0
0 1 0 0 1 05A 03C 096 0E1 027 1 05 23 0 B
1 1 0 0 1 05A 03C 096 0E1 027 1 05 23 0 0
0 1 0 0 1 05A 03C 096 0E1 027 1 05 23 0 2
1 1 0 0 1 05A 03C 096 0E1 027 1 05 23 0 0
0 1 0 0 1 05A 03C 096 0E1 027 1 05 23 0 3
0 1 0 0 0 05A 03C 096 0E1 027 0 00 00 0 3

// File: bench/tb_pce_pad_port.sv
// Testbench for the PC Engine pad port, replaying a stimulus trace against expected nibbles
module tb_pce_pad_port;
	timeunit 1ns;
	timeprecision 100ps;

	import pad_pkg::*;

	localparam int    CLK_PERIOD   = 20;
	localparam int    DRIVE_DELAY  = 1;
	localparam int    RESET_CYCLES = 10;
	localparam int    STEP_CYCLES  = 4;
	localparam int    SEED         = 39542;
	localparam string TRACE_FILE   = "bench/pad_trace.txt";

	typedef struct packed {
		logic            clr;
		logic            sel;
		logic            multitap;
		logic            six_button;
		logic            mouse;
		pad_word_t [4:0] pads;
		logic            strobe;
		logic [7:0]      dx;
		logic [7:0]      dy;
		logic [1:0]      btn;
		nibble_t         expect_nib;
	} step_t;

	logic       clk_sys;
	logic       reset;
	logic       joy_sel;
	logic       joy_clr;
	logic       cfg_multitap;
	logic       cfg_six_button;
	logic       cfg_mouse;
	pad_word_t  pad0;
	pad_word_t  pad1;
	pad_word_t  pad2;
	pad_word_t  pad3;
	pad_word_t  pad4;
	logic       mouse_strobe;
	logic [7:0] mouse_dx;
	logic [7:0] mouse_dy;
	logic [1:0] mouse_btn;
	nibble_t    pad_nibble;

	step_t steps[$];
	int    step_test[$];
	string test_names[$];
	bit    trace_loaded;
	int    test_checks;
	int    test_errors;
	int    total_checks;
	int    total_errors;

	pce_pad_port u_pce_pad_port (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.joy_sel        (joy_sel),
		.joy_clr        (joy_clr),
		.cfg_multitap   (cfg_multitap),
		.cfg_six_button (cfg_six_button),
		.cfg_mouse      (cfg_mouse),
		.pad0           (pad0),
		.pad1           (pad1),
		.pad2           (pad2),
		.pad3           (pad3),
		.pad4           (pad4),
		.mouse_strobe   (mouse_strobe),
		.mouse_dx       (mouse_dx),
		.mouse_dy       (mouse_dy),
		.mouse_btn      (mouse_btn),
		.pad_nibble     (pad_nibble)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ==============================
	// Helpers
	// ==============================

	task automatic finish_run(input bit passed);
		if (passed) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] want);
		test_checks++;
		total_checks++;
		if (got !== want) begin
			test_errors++;
			total_errors++;
			$display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, got, want);
		end
	endtask

	task automatic report_test(input int idx);
		$display("Test %s finished: %0d checks, %0d mismatches", test_names[idx],
			test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	function automatic string trim_end(input string s);
		int n;
		n = s.len();
		while (n > 0 && (s.getc(n - 1) == "\n" || s.getc(n - 1) == "\r" ||
			s.getc(n - 1) == " ")) begin
			n--;
		end
		return s.substr(0, n - 1);
	endfunction

	// One step per data line, test names from the marker lines
	task automatic load_trace(output bit ok);
		int          fd;
		int          n;
		string       line;
		logic [31:0] col [15];
		step_t       s;
		ok = 1'b1;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the trace file %s", TRACE_FILE);
			ok = 1'b0;
		end else begin
			while ($fgets(line, fd) != 0) begin
				line = trim_end(line);
				if (line.len() > 5 && line.substr(0, 4) == "test ") begin
					test_names.push_back(line.substr(5, line.len() - 1));
				end else if (line.len() > 0 && line.getc(0) != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
						col[8], col[9], col[10], col[11], col[12], col[13], col[14]);
					if (n != 15) begin
						$display("Trace line has the wrong number of columns: %s", line);
						ok = 1'b0;
					end else begin
						if (test_names.size() == 0) begin
							test_names.push_back("unnamed");
						end
						s.clr        = col[0][0];
						s.sel        = col[1][0];
						s.multitap   = col[2][0];
						s.six_button = col[3][0];
						s.mouse      = col[4][0];
						for (int i = 0; i < 5; i++) begin
							s.pads[i] = col[5 + i][11:0];
						end
						s.strobe     = col[10][0];
						s.dx         = col[11][7:0];
						s.dy         = col[12][7:0];
						s.btn        = col[13][1:0];
						s.expect_nib = col[14][3:0];
						steps.push_back(s);
						step_test.push_back(test_names.size() - 1);
					end
				end
			end
			$fclose(fd);
			if (steps.size() == 0) begin
				$display("The trace file holds no stimulus steps");
				ok = 1'b0;
			end
		end
	endtask

	task automatic apply_step(input step_t s);
		pad_word_t   pads [5];
		logic [31:0] rnd;
		for (int i = 0; i < 5; i++) begin
			pads[i] = s.pads[i];
			// Buttons III to VI stay hidden while the high bank is off
			if (!s.six_button) begin
				rnd = $urandom();
				pads[i][11:8] = rnd[3:0];
			end
		end
		joy_clr        = s.clr;
		joy_sel        = s.sel;
		cfg_multitap   = s.multitap;
		cfg_six_button = s.six_button;
		cfg_mouse      = s.mouse;
		pad0           = pads[0];
		pad1           = pads[1];
		pad2           = pads[2];
		pad3           = pads[3];
		pad4           = pads[4];
		mouse_strobe   = s.strobe;
		mouse_dx       = s.dx;
		mouse_dy       = s.dy;
		mouse_btn      = s.btn;
	endtask

	// ==============================
	// Watchdog
	// ==============================

	initial begin
		longint limit;
		wait (trace_loaded);
		limit = longint'(steps.size()) * STEP_CYCLES * CLK_PERIOD + 1000;
		#(limit);
		$display("Timeout: the trace did not finish in the expected time");
		finish_run(1'b0);
	end

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		bit ok;
		int cur;
		void'($urandom(SEED));
		reset          = 1'b1;
		joy_sel        = 1'b0;
		joy_clr        = 1'b0;
		cfg_multitap   = 1'b0;
		cfg_six_button = 1'b0;
		cfg_mouse      = 1'b0;
		pad0           = '0;
		pad1           = '0;
		pad2           = '0;
		pad3           = '0;
		pad4           = '0;
		mouse_strobe   = 1'b0;
		mouse_dx       = '0;
		mouse_dy       = '0;
		mouse_btn      = '0;
		load_trace(ok);
		trace_loaded = 1'b1;
		if (!ok) begin
			finish_run(1'b0);
		end else begin
			repeat (RESET_CYCLES) @(posedge clk_sys);
			#(DRIVE_DELAY);
			reset = 1'b0;
			// Output register still holds its reset value
			check_value("pad_nibble", pad_nibble, '0);
			cur = step_test[0];
			foreach (steps[i]) begin
				if (step_test[i] != cur) begin
					report_test(cur);
					cur = step_test[i];
				end
				apply_step(steps[i]);
				repeat (STEP_CYCLES) @(posedge clk_sys);
				#(DRIVE_DELAY);
				check_value("pad_nibble", pad_nibble, steps[i].expect_nib);
			end
			report_test(cur);
			$display("Totals: %0d checks, %0d mismatches", total_checks, total_errors);
			finish_run(total_errors == 0);
		end
	end

endmodule

// File: hdl/mouse_track.sv
// Mouse movement capture, nibble counter and inactivity timeout
module mouse_track #(
	parameter int TIMEOUT_WIDTH = 15
) (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             joy_clr,
	input  logic             clr_rise,
	input  logic             mouse_strobe,
	input  logic [7:0]       mouse_dx,
	input  logic [7:0]       mouse_dy,
	output pad_pkg::nibble_t mouse_nib_hi
);

	logic                     strobe_d1;
	logic                     strobe_d2;
	logic [7:0]               dx_d1;
	logic [7:0]               dy_d1;
	logic [7:0]               pend_x;
	logic [7:0]               pend_y;
	logic [7:0]               rep_x;
	logic [7:0]               rep_y;
	logic [1:0]               count;
	logic [TIMEOUT_WIDTH-1:0] timeout;

	// ==============================
	// Input stage
	// ==============================

	always_ff @(posedge clk_sys) begin
		dx_d1 <= mouse_dx;
		dy_d1 <= mouse_dy;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			strobe_d1 <= 1'b0;
			strobe_d2 <= 1'b0;
		end else begin
			strobe_d1 <= mouse_strobe;
			strobe_d2 <= strobe_d1;
		end
	end

	// ==============================
	// Movement and scan count
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pend_x  <= '0;
			pend_y  <= '0;
			rep_x   <= '0;
			rep_y   <= '0;
			count   <= '0;
			timeout <= '0;
		end else begin
			if (joy_clr) begin
				timeout <= '0;
			end else if (~&timeout) begin
				timeout <= timeout + 1'b1;
			end

			// Idle console, next clear starts a fresh report
			if (&timeout) begin
				count <= 2'd3;
			end

			if (clr_rise) begin
				count <= count + 2'd1;
				if (count == 2'd3) begin
					rep_x  <= pend_x;
					rep_y  <= pend_y;
					pend_x <= '0;
					pend_y <= '0;
				end
			end

			// X axis runs the other way on the console
			if (strobe_d1 ^ strobe_d2) begin
				pend_x <= 8'd0 - dx_d1;
				pend_y <= dy_d1;
			end
		end
	end

	always_comb begin
		case (count)
			2'd0: mouse_nib_hi = rep_x[7:4];
			2'd1: mouse_nib_hi = rep_x[3:0];
			2'd2: mouse_nib_hi = rep_y[7:4];
			default: mouse_nib_hi = rep_y[3:0];
		endcase
	end

endmodule

// File: hdl/nibble_result.sv
// Result stage latching one nibble of the response word for the console
module nibble_result (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                joy_clr,
	input  logic                joy_sel,
	input  logic                high_bank,
	input  pad_pkg::resp_word_t resp,
	output pad_pkg::nibble_t    pad_nibble
);
	import pad_pkg::*;

	bank_t   bank;
	nibble_t nib_sel;

	// High bank picks nibbles 2 and 3, select picks odd
	assign bank    = {high_bank, joy_sel};
	assign nib_sel = resp[bank*NIB_W +: NIB_W];

	// ==============================
	// Output latch
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pad_nibble <= '0;
		end else if (joy_clr) begin
			// Console reads all lines low during clear
			pad_nibble <= '0;
		end else begin
			pad_nibble <= nib_sel;
		end
	end

endmodule

// File: hdl/pad_decode.sv
// Pad decode stage building the active-low response word of the selected port
module pad_decode #(
	parameter int NUM_PORTS = 5,
	localparam int PORT_W = $clog2(NUM_PORTS + 1)
) (
	input  pad_pkg::pad_word_t [NUM_PORTS-1:0] pads,
	input  logic [PORT_W-1:0]                 port,
	input  logic                              cfg_mouse,
	input  logic [1:0]                        mouse_btn,
	input  pad_pkg::nibble_t                  mouse_nib_hi,
	output pad_pkg::resp_word_t               resp
);
	import pad_pkg::*;

	pad_word_t  sel_pad;
	resp_word_t pad_resp;
	logic [7:0] mouse_byte;

	// ==============================
	// Port select
	// ==============================

	// Compare instead of index so ports past the end never address the array
	always_comb begin
		sel_pad = pads[0];
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (port == i) begin
				sel_pad = pads[i];
			end
		end
	end

	// ==============================
	// Pad reorder
	// ==============================

	always_comb begin
		// Run, Select, II, I
		pad_resp[BANK_BUTTONS*NIB_W +: NIB_W] = ~{sel_pad[PAD_RUN], sel_pad[PAD_SELECT],
			sel_pad[PAD_II], sel_pad[PAD_I]};

		// Right, down, up, left
		pad_resp[BANK_DPAD*NIB_W +: NIB_W] = ~{sel_pad[PAD_RIGHT], sel_pad[PAD_DOWN],
			sel_pad[PAD_UP], sel_pad[PAD_LEFT]};

		// Six-button bank, III to VI
		pad_resp[BANK_EXTRA*NIB_W +: NIB_W] = ~sel_pad[PAD_EXT_LSB +: NIB_W];

		// Fourth nibble reads all pressed, which marks a six-button pad
		pad_resp[BANK_BLANK*NIB_W +: NIB_W] = '0;
	end

	// Mouse byte, buttons low and one movement nibble high
	assign mouse_byte[3:0] = ~{pads[0][PAD_RUN], pads[0][PAD_SELECT], mouse_btn[0],
		mouse_btn[1]};
	assign mouse_byte[7:4] = mouse_nib_hi;

	// ==============================
	// Word select
	// ==============================

	always_comb begin
		if (port == 0 && cfg_mouse) begin
			resp = {mouse_byte, mouse_byte};
		end else if (port < NUM_PORTS) begin
			resp = pad_resp;
		end else begin
			resp = RESP_IDLE;
		end
	end

endmodule

// File: hdl/pad_pkg.sv
// PC Engine pad port types, pad field positions and nibble bank codes
package pad_pkg;

	// ==============================
	// Widths and types
	// ==============================

	localparam int NIB_W = 4;

	// Raw controller, active high
	typedef logic [11:0] pad_word_t;

	// Active-low response, four nibbles
	typedef logic [15:0] resp_word_t;

	typedef logic [NIB_W-1:0] nibble_t;

	// {high bank flag, select level}
	typedef logic [1:0] bank_t;

	// ==============================
	// Pad word fields
	// ==============================

	localparam int PAD_UP      = 0;
	localparam int PAD_DOWN    = 1;
	localparam int PAD_LEFT    = 2;
	localparam int PAD_RIGHT   = 3;
	localparam int PAD_I       = 4;
	localparam int PAD_II      = 5;
	localparam int PAD_SELECT  = 6;
	localparam int PAD_RUN     = 7;
	localparam int PAD_EXT_LSB = 8;   // buttons III to VI

	// Nibble position inside a response word
	localparam bank_t BANK_BUTTONS = 2'b00;
	localparam bank_t BANK_DPAD    = 2'b01;
	localparam bank_t BANK_EXTRA   = 2'b10;
	localparam bank_t BANK_BLANK   = 2'b11;

	// Port past the last pad
	localparam resp_word_t RESP_IDLE = 16'h0FFF;

endpackage

// File: hdl/pce_pad_port.sv
// PC Engine game-pad port with multitap, six-button and mouse support
module pce_pad_port (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               joy_sel,
	input  logic               joy_clr,
	input  logic               cfg_multitap,
	input  logic               cfg_six_button,
	input  logic               cfg_mouse,
	input  pad_pkg::pad_word_t pad0,
	input  pad_pkg::pad_word_t pad1,
	input  pad_pkg::pad_word_t pad2,
	input  pad_pkg::pad_word_t pad3,
	input  pad_pkg::pad_word_t pad4,
	input  logic               mouse_strobe,
	input  logic [7:0]         mouse_dx,
	input  logic [7:0]         mouse_dy,
	input  logic [1:0]         mouse_btn,
	output pad_pkg::nibble_t   pad_nibble
);
	import pad_pkg::*;

	localparam int NUM_PORTS     = 5;
	localparam int TIMEOUT_WIDTH = 15;
	localparam int PORT_W        = $clog2(NUM_PORTS + 1);

	pad_word_t [NUM_PORTS-1:0] pads;
	logic [PORT_W-1:0]         port;
	logic                      high_bank;
	logic                      clr_rise;
	nibble_t                   mouse_nib_hi;
	resp_word_t                resp;

	assign pads = {pad4, pad3, pad2, pad1, pad0};

	// ==============================
	// Stages
	// ==============================

	tap_scan #(.NUM_PORTS(NUM_PORTS)) u_tap_scan (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.joy_sel        (joy_sel),
		.joy_clr        (joy_clr),
		.cfg_multitap   (cfg_multitap),
		.cfg_six_button (cfg_six_button),
		.port           (port),
		.high_bank      (high_bank),
		.clr_rise       (clr_rise)
	);

	mouse_track #(.TIMEOUT_WIDTH(TIMEOUT_WIDTH)) u_mouse_track (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.joy_clr      (joy_clr),
		.clr_rise     (clr_rise),
		.mouse_strobe (mouse_strobe),
		.mouse_dx     (mouse_dx),
		.mouse_dy     (mouse_dy),
		.mouse_nib_hi (mouse_nib_hi)
	);

	pad_decode #(.NUM_PORTS(NUM_PORTS)) u_pad_decode (
		.pads         (pads),
		.port         (port),
		.cfg_mouse    (cfg_mouse),
		.mouse_btn    (mouse_btn),
		.mouse_nib_hi (mouse_nib_hi),
		.resp         (resp)
	);

	nibble_result u_nibble_result (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.joy_clr    (joy_clr),
		.joy_sel    (joy_sel),
		.high_bank  (high_bank),
		.resp       (resp),
		.pad_nibble (pad_nibble)
	);

endmodule

// File: hdl/tap_scan.sv
// Strobe edge detect, multitap port counter and six-button bank toggle
module tap_scan #(
	parameter int NUM_PORTS = 5,
	localparam int PORT_W = $clog2(NUM_PORTS + 1)
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              joy_sel,
	input  logic              joy_clr,
	input  logic              cfg_multitap,
	input  logic              cfg_six_button,
	output logic [PORT_W-1:0] port,
	output logic              high_bank,
	output logic              clr_rise
);

	logic sel_q;
	logic clr_q;
	logic sel_rise;

	// ==============================
	// Strobe edges
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel_q <= 1'b0;
			clr_q <= 1'b0;
		end else begin
			sel_q <= joy_sel;
			clr_q <= joy_clr;
		end
	end

	assign sel_rise = joy_sel & ~sel_q;
	assign clr_rise = joy_clr & ~clr_q;

	// ==============================
	// Port counter and bank
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port      <= '0;
			high_bank <= 1'b0;
		end else if (joy_clr) begin
			// Clear restarts the scan at the first port
			port <= '0;
			if (clr_rise) begin
				high_bank <= ~high_bank & cfg_six_button;
			end
		end else if (sel_rise && cfg_multitap) begin
			// Counter wraps, ports past the end read idle
			port <= port + 1'b1;
		end
	end

endmodule

// File: pce_pad_port.f
hdl/pad_pkg.sv
hdl/pad_decode.sv
hdl/tap_scan.sv
hdl/mouse_track.sv
hdl/nibble_result.sv
hdl/pce_pad_port.sv
bench/tb_pce_pad_port.sv
